// ==== logic/axi_bridge_cfg.svh ====
`ifndef AXI_BRIDGE_CFG_SVH
`define AXI_BRIDGE_CFG_SVH

// bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// one cache line is a full 16-beat burst
`define BRIDGE_LINE_WORDS 16
`define BRIDGE_LINE_W 512

// read ids, also used to steer the return data
`define BRIDGE_ID_W 4
`define BRIDGE_ID_ICACHE 0
`define BRIDGE_ID_DCACHE 1

// AXI burst type codes
`define BRIDGE_BURST_FIXED 0
`define BRIDGE_BURST_INCR 1

`endif

// ==== logic/axi_bridge_pkg.sv ====
`include "axi_bridge_cfg.svh"

package axi_bridge_pkg;

	typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
	typedef logic [`BRIDGE_DATA_W-1:0] data_t;
	typedef logic [`BRIDGE_DATA_W/8-1:0] strb_t;
	typedef logic [`BRIDGE_LINE_W-1:0] line_t;
	typedef logic [`BRIDGE_ID_W-1:0] axi_id_t;
	typedef logic [3:0] axi_len_t; // beats minus one
	typedef logic [2:0] axi_size_t;
	typedef logic [1:0] axi_burst_t;

	// sram-style cache side
	typedef struct packed {
		logic req;
		axi_size_t size;
		addr_t addr;
	} cache_rd_req_t;

	typedef struct packed {
		cache_rd_req_t rd;
		logic uncached; // single beat, fixed burst
	} dcache_rd_req_t;

	typedef struct packed {
		logic valid;
		logic last;
		data_t data;
	} cache_ret_t;

	typedef struct packed {
		logic req;
		logic uncached; // only the low word of line is sent
		axi_size_t size;
		strb_t wstrb;
		addr_t addr;
		line_t line;
	} cache_wr_req_t;

	// read command from arbiter to read engine
	typedef struct packed {
		axi_id_t id;
		addr_t addr;
		axi_size_t size;
		axi_len_t len;
		axi_burst_t burst;
	} rd_cmd_t;

	// AXI channels
	typedef struct packed {
		logic valid;
		axi_id_t id;
		addr_t addr;
		axi_len_t len;
		axi_size_t size;
		axi_burst_t burst;
	} axi_ar_t;

	typedef struct packed {
		logic valid;
		addr_t addr;
		axi_len_t len;
		axi_size_t size;
		axi_burst_t burst;
	} axi_aw_t;

	typedef struct packed {
		logic valid;
		data_t data;
		strb_t strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		logic valid;
		data_t data;
		logic last;
	} axi_r_t;

	// write in flight, for the read hazard check
	typedef struct packed {
		logic busy;
		addr_t addr;
	} wr_status_t;

endpackage

// ==== logic/read_arbiter.sv ====
`include "axi_bridge_cfg.svh"

module read_arbiter (
	input logic clk,
	input logic rst,
	input axi_bridge_pkg::cache_rd_req_t icache_rd,
	input axi_bridge_pkg::dcache_rd_req_t dcache_rd,
	input logic rd_idle,
	input axi_bridge_pkg::wr_status_t wr_status,
	output logic icache_rd_rdy,
	output logic dcache_rd_rdy,
	output logic cmd_valid,
	output axi_bridge_pkg::rd_cmd_t cmd
);

	logic hazard_i;
	logic hazard_d;
	logic free;
	logic icache_acc;
	logic dcache_acc;
	axi_bridge_pkg::rd_cmd_t next_cmd;

	// a read to the line being written waits for the B response
	assign hazard_i = wr_status.busy && (icache_rd.addr == wr_status.addr);
	assign hazard_d = wr_status.busy && (dcache_rd.rd.addr == wr_status.addr);

	// cmd_valid cycle still shows the engine idle, so block it here
	assign free = rd_idle && !cmd_valid;

	assign icache_rd_rdy = free && !hazard_i;
	assign dcache_rd_rdy = free && !icache_rd.req && !hazard_d; // icache has priority

	assign icache_acc = icache_rd.req && icache_rd_rdy;
	assign dcache_acc = dcache_rd.rd.req && dcache_rd_rdy;

	always_comb begin
		if (icache_acc) begin
			next_cmd.id = axi_bridge_pkg::axi_id_t'(`BRIDGE_ID_ICACHE);
			next_cmd.addr = icache_rd.addr;
			next_cmd.size = icache_rd.size;
			next_cmd.len = axi_bridge_pkg::axi_len_t'(`BRIDGE_LINE_WORDS - 1);
			next_cmd.burst = axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR);
		end else begin
			next_cmd.id = axi_bridge_pkg::axi_id_t'(`BRIDGE_ID_DCACHE);
			next_cmd.addr = dcache_rd.rd.addr;
			next_cmd.size = dcache_rd.rd.size;
			if (dcache_rd.uncached) begin
				// uncached load is a single fixed beat
				next_cmd.len = '0;
				next_cmd.burst = axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_FIXED);
			end else begin
				next_cmd.len = axi_bridge_pkg::axi_len_t'(`BRIDGE_LINE_WORDS - 1);
				next_cmd.burst = axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= icache_acc || dcache_acc; // one-cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (icache_acc || dcache_acc) begin
			cmd <= next_cmd;
		end
	end

endmodule

// ==== logic/read_channel.sv ====
`include "axi_bridge_cfg.svh"

module read_channel (
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input axi_bridge_pkg::rd_cmd_t cmd,
	input logic ar_ready,
	input axi_bridge_pkg::axi_r_t r,
	output axi_bridge_pkg::axi_ar_t ar,
	output logic rd_idle,
	output axi_bridge_pkg::cache_ret_t icache_ret,
	output axi_bridge_pkg::cache_ret_t dcache_ret
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_t;

	rd_state_t state;
	rd_state_t state_nxt;
	axi_bridge_pkg::rd_cmd_t cmd_q;
	logic beat;
	logic to_dcache;

	always_comb begin
		state_nxt = state;
		case (state)
			RD_IDLE: begin
				if (cmd_valid) begin
					state_nxt = RD_ADDR;
				end
			end
			RD_ADDR: begin
				if (ar_ready) begin
					state_nxt = RD_DATA;
				end
			end
			RD_DATA: begin
				if (r.valid && r.last) begin
					state_nxt = RD_IDLE; // burst done, next request may go
				end
			end
			default: state_nxt = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= RD_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// command held for the whole burst
	always_ff @(posedge clk) begin
		if (state == RD_IDLE && cmd_valid) begin
			cmd_q <= cmd;
		end
	end

	assign rd_idle = (state == RD_IDLE);

	assign ar.valid = (state == RD_ADDR);
	assign ar.id = cmd_q.id;
	assign ar.addr = cmd_q.addr;
	assign ar.len = cmd_q.len;
	assign ar.size = cmd_q.size;
	assign ar.burst = cmd_q.burst;

	// rready is tied high, every valid beat in DATA is taken
	assign beat = (state == RD_DATA) && r.valid;
	assign to_dcache = (cmd_q.id == axi_bridge_pkg::axi_id_t'(`BRIDGE_ID_DCACHE));

	assign icache_ret.valid = beat && !to_dcache;
	assign icache_ret.last = beat && !to_dcache && r.last;
	assign icache_ret.data = r.data;

	assign dcache_ret.valid = beat && to_dcache;
	assign dcache_ret.last = beat && to_dcache && r.last;
	assign dcache_ret.data = r.data;

endmodule

// ==== logic/write_channel.sv ====
`include "axi_bridge_cfg.svh"

module write_channel (
	input logic clk,
	input logic rst,
	input axi_bridge_pkg::cache_wr_req_t dcache_wr,
	input logic aw_ready,
	input logic w_ready,
	input logic b_valid,
	output logic dcache_wr_rdy,
	output axi_bridge_pkg::axi_aw_t aw,
	output axi_bridge_pkg::axi_w_t w,
	output axi_bridge_pkg::wr_status_t wr_status
);

	localparam int BEAT_W = $clog2(`BRIDGE_LINE_WORDS);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_t;

	wr_state_t state;
	wr_state_t state_nxt;
	logic accept;
	logic w_fire;
	logic [BEAT_W-1:0] beat_cnt;

	// captured request
	axi_bridge_pkg::addr_t addr_q;
	axi_bridge_pkg::axi_size_t size_q;
	axi_bridge_pkg::strb_t wstrb_q;
	axi_bridge_pkg::line_t line_q; // word 0 always at the bottom
	logic uncached_q;

	assign dcache_wr_rdy = (state == WR_IDLE);
	assign accept = dcache_wr.req && dcache_wr_rdy;
	assign w_fire = w.valid && w_ready;

	always_comb begin
		state_nxt = state;
		case (state)
			WR_IDLE: begin
				if (accept) begin
					state_nxt = WR_ADDR;
				end
			end
			WR_ADDR: begin
				if (aw_ready) begin
					state_nxt = WR_DATA;
				end
			end
			WR_DATA: begin
				if (w_fire && w.last) begin
					state_nxt = WR_RESP;
				end
			end
			WR_RESP: begin
				// bready tied high
				if (b_valid) begin
					state_nxt = WR_IDLE;
				end
			end
			default: state_nxt = WR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= WR_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			beat_cnt <= '0;
		end else if (accept) begin
			beat_cnt <= '0;
		end else if (w_fire) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= dcache_wr.addr;
			size_q <= dcache_wr.size;
			wstrb_q <= dcache_wr.wstrb;
			uncached_q <= dcache_wr.uncached;
		end
	end

	// shift one word down per accepted beat
	always_ff @(posedge clk) begin
		if (accept) begin
			line_q <= dcache_wr.line;
		end else if (w_fire) begin
			line_q <= {{`BRIDGE_DATA_W{1'b0}}, line_q[`BRIDGE_LINE_W-1:`BRIDGE_DATA_W]};
		end
	end

	assign aw.valid = (state == WR_ADDR);
	assign aw.addr = addr_q;
	assign aw.size = size_q;
	assign aw.len = uncached_q ? '0 : axi_bridge_pkg::axi_len_t'(`BRIDGE_LINE_WORDS - 1);
	assign aw.burst = uncached_q ? axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_FIXED)
		: axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR);

	assign w.valid = (state == WR_DATA);
	assign w.data = line_q[`BRIDGE_DATA_W-1:0];
	assign w.strb = wstrb_q; // same strobe on every beat
	assign w.last = uncached_q || (beat_cnt == BEAT_W'(`BRIDGE_LINE_WORDS - 1));

	// held until the response, reads to addr_q wait on this
	assign wr_status.busy = (state != WR_IDLE);
	assign wr_status.addr = addr_q;

endmodule

// ==== logic/axi_sram_bridge.sv ====
module axi_sram_bridge (
	input logic clk,
	input logic rst, // active low

	// instruction cache read port
	input axi_bridge_pkg::cache_rd_req_t icache_rd,
	output logic icache_rd_rdy,
	output axi_bridge_pkg::cache_ret_t icache_ret,

	// data cache read and write ports
	input axi_bridge_pkg::dcache_rd_req_t dcache_rd,
	output logic dcache_rd_rdy,
	output axi_bridge_pkg::cache_ret_t dcache_ret,
	input axi_bridge_pkg::cache_wr_req_t dcache_wr,
	output logic dcache_wr_rdy,

	// AXI read
	output axi_bridge_pkg::axi_ar_t ar,
	input logic ar_ready,
	input axi_bridge_pkg::axi_r_t r,

	// AXI write
	output axi_bridge_pkg::axi_aw_t aw,
	input logic aw_ready,
	output axi_bridge_pkg::axi_w_t w,
	input logic w_ready,
	input logic b_valid
);

	logic cmd_valid;
	logic rd_idle;
	axi_bridge_pkg::rd_cmd_t cmd;
	axi_bridge_pkg::wr_status_t wr_status;

	read_arbiter i_read_arbiter (
		.clk(clk),
		.rst(rst),
		.icache_rd(icache_rd),
		.dcache_rd(dcache_rd),
		.rd_idle(rd_idle),
		.wr_status(wr_status),
		.icache_rd_rdy(icache_rd_rdy),
		.dcache_rd_rdy(dcache_rd_rdy),
		.cmd_valid(cmd_valid),
		.cmd(cmd)
	);

	read_channel i_read_channel (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.ar_ready(ar_ready),
		.r(r),
		.ar(ar),
		.rd_idle(rd_idle),
		.icache_ret(icache_ret),
		.dcache_ret(dcache_ret)
	);

	write_channel i_write_channel (
		.clk(clk),
		.rst(rst),
		.dcache_wr(dcache_wr),
		.aw_ready(aw_ready),
		.w_ready(w_ready),
		.b_valid(b_valid),
		.dcache_wr_rdy(dcache_wr_rdy),
		.aw(aw),
		.w(w),
		.wr_status(wr_status)
	);

endmodule

// ==== verification/tb_axi_mem.sv ====
`include "axi_bridge_cfg.svh"

module tb_axi_mem (
	input logic clk,
	input logic rst,
	input axi_bridge_pkg::axi_ar_t ar,
	output logic ar_ready,
	output axi_bridge_pkg::axi_r_t r,
	input axi_bridge_pkg::axi_aw_t aw,
	output logic aw_ready,
	input axi_bridge_pkg::axi_w_t w,
	output logic w_ready,
	output logic b_valid
);

	timeunit 1ns;
	timeprecision 1ns;

	logic [31:0] mem [logic [29:0]]; // keyed by word address
	logic rd_busy;
	logic rd_fixed;
	logic [31:0] rd_addr;
	int rd_left;
	logic wr_fixed;
	logic [31:0] wr_addr;
	int b_wait;

	// untouched words read back as the power-up pattern
	function automatic logic [31:0] backing_word(input logic [31:0] addr);
		if (mem.exists(addr[31:2])) begin
			return mem[addr[31:2]];
		end
		return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
	endfunction

	initial begin
		ar_ready = 1'b0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		r = '0;
		b_valid = 1'b0;
		rd_busy = 1'b0;
		rd_left = 0;
		b_wait = 0;
	end

	// handshakes seen at the rising edge
	always @(posedge clk) begin
		logic [31:0] word;
		if (r.valid) begin
			rd_left = rd_left - 1;
			rd_addr = rd_fixed ? rd_addr : rd_addr + 32'd4;
			rd_busy = (rd_left != 0);
		end
		if (ar.valid && ar_ready) begin
			rd_busy = 1'b1;
			rd_addr = ar.addr;
			rd_left = int'(ar.len) + 1;
			rd_fixed = (ar.burst == axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_FIXED));
		end
		if (aw.valid && aw_ready) begin
			wr_addr = aw.addr;
			wr_fixed = (aw.burst == axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_FIXED));
		end
		if (w.valid && w_ready) begin
			word = backing_word(wr_addr);
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i]) begin
					word[8*i +: 8] = w.data[8*i +: 8];
				end
			end
			mem[wr_addr[31:2]] = word;
			wr_addr = wr_fixed ? wr_addr : wr_addr + 32'd4;
			if (w.last) begin
				b_wait = 1 + int'($urandom % 3); // response 1 to 3 cycles later
			end
		end
	end

	// random stalls, new values on the falling edge
	always @(negedge clk) begin
		ar_ready = ($urandom % 3) != 0;
		aw_ready = ($urandom % 3) != 0;
		w_ready = ($urandom % 4) != 0;
		r.valid = rst && rd_busy && (($urandom % 4) != 0);
		r.data = backing_word(rd_addr);
		r.last = (rd_left == 1);
		b_valid = 1'b0;
		if (b_wait != 0) begin
			b_wait = b_wait - 1;
			b_valid = (b_wait == 0);
		end
	end

endmodule

// ==== verification/tb_axi_sram_bridge.sv ====
`include "axi_bridge_cfg.svh"

module tb_axi_sram_bridge;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int TIMEOUT = 300; // cycles per wait
	localparam logic [2:0] WORD_SIZE = 3'd2; // 4-byte beats

	typedef struct packed {
		logic dside;
		logic [31:0] addr;
		logic [4:0] beats;
	} rd_exp_t;

	typedef struct packed {
		logic uncached;
		logic [31:0] addr;
		axi_bridge_pkg::line_t line;
	} wr_exp_t;

	logic clk;
	logic rst;
	axi_bridge_pkg::cache_rd_req_t icache_rd;
	axi_bridge_pkg::dcache_rd_req_t dcache_rd;
	axi_bridge_pkg::cache_wr_req_t dcache_wr;
	logic icache_rd_rdy;
	logic dcache_rd_rdy;
	logic dcache_wr_rdy;
	axi_bridge_pkg::cache_ret_t icache_ret;
	axi_bridge_pkg::cache_ret_t dcache_ret;
	axi_bridge_pkg::axi_ar_t ar;
	axi_bridge_pkg::axi_aw_t aw;
	axi_bridge_pkg::axi_w_t w;
	axi_bridge_pkg::axi_r_t r;
	logic ar_ready;
	logic aw_ready;
	logic w_ready;
	logic b_valid;

	logic [31:0] shadow [logic [29:0]]; // words the testbench has written
	rd_exp_t rd_q[$];
	wr_exp_t wr_q[$];
	int rd_beat = 0;
	int w_beat = 0;
	int b_seen = 0;
	int wr_issued = 0;

	axi_sram_bridge i_axi_sram_bridge (
		.clk(clk), .rst(rst),
		.icache_rd(icache_rd), .icache_rd_rdy(icache_rd_rdy), .icache_ret(icache_ret),
		.dcache_rd(dcache_rd), .dcache_rd_rdy(dcache_rd_rdy), .dcache_ret(dcache_ret),
		.dcache_wr(dcache_wr), .dcache_wr_rdy(dcache_wr_rdy),
		.ar(ar), .ar_ready(ar_ready), .r(r),
		.aw(aw), .aw_ready(aw_ready), .w(w), .w_ready(w_ready), .b_valid(b_valid)
	);

	tb_axi_mem i_axi_mem (
		.clk(clk), .rst(rst), .ar(ar), .ar_ready(ar_ready), .r(r),
		.aw(aw), .aw_ready(aw_ready), .w(w), .w_ready(w_ready), .b_valid(b_valid)
	);

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (shadow.exists(addr[31:2])) begin
			return shadow[addr[31:2]];
		end
		return mem_word(addr);
	endfunction

	function automatic axi_bridge_pkg::line_t random_line();
		axi_bridge_pkg::line_t l;
		for (int k = 0; k < `BRIDGE_LINE_WORDS; k++) begin
			l[32*k +: 32] = $urandom;
		end
		return l;
	endfunction

	task automatic abort_test(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic issue_read(input logic dside, input logic [31:0] addr, input logic uncached,
			output int b_at_accept);
		logic taken;
		@(negedge clk);
		if (dside) begin
			dcache_rd.rd.req = 1'b1;
			dcache_rd.rd.size = WORD_SIZE;
			dcache_rd.rd.addr = addr;
			dcache_rd.uncached = uncached;
		end else begin
			icache_rd.req = 1'b1;
			icache_rd.size = WORD_SIZE;
			icache_rd.addr = addr;
		end
		taken = 1'b0;
		for (int n = 0; n < TIMEOUT && !taken; n++) begin
			@(posedge clk);
			taken = dside ? dcache_rd_rdy : icache_rd_rdy;
		end
		assert (taken) else abort_test("read request was not accepted before the timeout");
		b_at_accept = b_seen;
		rd_q.push_back(rd_exp_t'{dside: dside, addr: addr,
			beats: (dside && uncached) ? 5'd1 : 5'd16});
		@(negedge clk);
		if (dside) begin
			dcache_rd.rd.req = 1'b0;
		end else begin
			icache_rd.req = 1'b0;
		end
	endtask

	task automatic issue_write(input logic [31:0] addr, input logic uncached,
			input axi_bridge_pkg::line_t line);
		logic taken;
		@(negedge clk);
		dcache_wr = '{req: 1'b1, uncached: uncached, size: WORD_SIZE, wstrb: 4'hf,
			addr: addr, line: line};
		taken = 1'b0;
		for (int n = 0; n < TIMEOUT && !taken; n++) begin
			@(posedge clk);
			taken = dcache_wr_rdy;
		end
		assert (taken) else abort_test("write request was not accepted before the timeout");
		wr_q.push_back(wr_exp_t'{uncached: uncached, addr: addr, line: line});
		wr_issued++;
		for (int k = 0; k < (uncached ? 1 : `BRIDGE_LINE_WORDS); k++) begin
			shadow[addr[31:2] + 30'(k)] = line[32*k +: 32];
		end
		@(negedge clk);
		dcache_wr.req = 1'b0;
	endtask

	task automatic wait_reads_done();
		for (int n = 0; n < TIMEOUT && rd_q.size() != 0; n++) begin
			@(posedge clk);
		end
		assert (rd_q.size() == 0) else abort_test("read data did not return before the timeout");
	endtask

	task automatic wait_writes_done();
		for (int n = 0; n < TIMEOUT && b_seen != wr_issued; n++) begin
			@(posedge clk);
		end
		assert (b_seen == wr_issued) else abort_test("write response did not arrive in time");
	endtask

	// every returned beat and read address against the reference
	always @(posedge clk) begin
		rd_exp_t cur;
		axi_bridge_pkg::cache_ret_t got;
		logic [31:0] want;
		string name;
		axi_bridge_pkg::axi_id_t id_exp;
		axi_bridge_pkg::axi_burst_t burst_exp;
		// icache has priority over dcache
		assert (!(rst && icache_rd.req && dcache_rd_rdy))
			else abort_test("data cache read was offered while the instruction cache requested");
		if (rst && (icache_ret.valid || dcache_ret.valid)) begin
			assert (rd_q.size() != 0) else abort_test("return beat arrived with no read outstanding");
			cur = rd_q[0];
			got = cur.dside ? dcache_ret : icache_ret;
			name = cur.dside ? "dcache_ret" : "icache_ret";
			want = expected_word(cur.addr + 32'(4 * rd_beat));
			assert (got.valid && !(cur.dside ? icache_ret.valid : dcache_ret.valid))
				else abort_test("return beat went to the cache that did not request it");
			assert (got.data == want)
				else abort_test($sformatf("ERROR %s.data got %h expected %h", name, got.data, want));
			assert (got.last == (rd_beat == int'(cur.beats) - 1))
				else abort_test($sformatf("ERROR %s.last got %h expected %h", name, got.last,
					rd_beat == int'(cur.beats) - 1));
			if (got.last) begin
				void'(rd_q.pop_front());
				rd_beat = 0;
			end else begin
				rd_beat++;
			end
		end
		if (rst && ar.valid && ar_ready) begin
			assert (rd_q.size() != 0) else abort_test("read address issued with no read outstanding");
			id_exp = rd_q[0].dside ? axi_bridge_pkg::axi_id_t'(`BRIDGE_ID_DCACHE)
				: axi_bridge_pkg::axi_id_t'(`BRIDGE_ID_ICACHE);
			burst_exp = (rd_q[0].beats == 5'd1)
				? axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_FIXED)
				: axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR);
			assert (ar.addr == rd_q[0].addr)
				else abort_test($sformatf("ERROR ar.addr got %h expected %h", ar.addr, rd_q[0].addr));
			assert (ar.len == 4'(rd_q[0].beats - 5'd1))
				else abort_test($sformatf("ERROR ar.len got %h expected %h", ar.len,
					rd_q[0].beats - 5'd1));
			assert (ar.id == id_exp)
				else abort_test($sformatf("ERROR ar.id got %h expected %h", ar.id, id_exp));
			assert (ar.size == WORD_SIZE)
				else abort_test($sformatf("ERROR ar.size got %h expected %h", ar.size, WORD_SIZE));
			assert (ar.burst == burst_exp)
				else abort_test($sformatf("ERROR ar.burst got %h expected %h", ar.burst,
					burst_exp));
		end
	end

	// write address and data beats against the issued line
	always @(posedge clk) begin
		wr_exp_t cur;
		logic [31:0] want;
		logic last_exp;
		axi_bridge_pkg::axi_len_t len_exp;
		axi_bridge_pkg::axi_burst_t burst_exp;
		if (rst && aw.valid && aw_ready) begin
			assert (wr_q.size() != 0) else abort_test("write address issued with no write outstanding");
			len_exp = wr_q[0].uncached ? 4'd0 : 4'd15;
			burst_exp = wr_q[0].uncached ? axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_FIXED)
				: axi_bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR);
			assert (aw.addr == wr_q[0].addr)
				else abort_test($sformatf("ERROR aw.addr got %h expected %h", aw.addr, wr_q[0].addr));
			assert (aw.len == len_exp)
				else abort_test($sformatf("ERROR aw.len got %h expected %h", aw.len, len_exp));
			assert (aw.size == WORD_SIZE)
				else abort_test($sformatf("ERROR aw.size got %h expected %h", aw.size, WORD_SIZE));
			assert (aw.burst == burst_exp)
				else abort_test($sformatf("ERROR aw.burst got %h expected %h", aw.burst,
					burst_exp));
		end
		if (rst && w.valid && w_ready) begin
			assert (wr_q.size() != 0) else abort_test("write beat sent with no write outstanding");
			cur = wr_q[0];
			want = cur.line[32*w_beat +: 32]; // beat k carries word k
			last_exp = cur.uncached || (w_beat == `BRIDGE_LINE_WORDS - 1);
			assert (w.data == want)
				else abort_test($sformatf("ERROR w.data got %h expected %h", w.data, want));
			assert (w.strb == 4'hf)
				else abort_test($sformatf("ERROR w.strb got %h expected %h", w.strb, 4'hf));
			assert (w.last == last_exp)
				else abort_test($sformatf("ERROR w.last got %h expected %h", w.last, last_exp));
			if (w.last) begin
				void'(wr_q.pop_front());
				w_beat = 0;
			end else begin
				w_beat++;
			end
		end
		if (b_valid) begin
			b_seen <= b_seen + 1;
		end
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		int b_acc;
		int b_other;
		int b_start;
		logic [31:0] addr;
		void'($urandom(32'h57af));
		icache_rd = '0;
		dcache_rd = '0;
		dcache_wr = '0;
		rst = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// single bursts from each side, then an uncached load
		issue_read(1'b0, 32'h0000_1000, 1'b0, b_acc);
		issue_read(1'b1, 32'h0000_2040, 1'b0, b_acc);
		issue_read(1'b1, 32'h0000_2084, 1'b1, b_acc);
		wait_reads_done();

		// both caches in the same cycle and icache goes first
		fork
			issue_read(1'b0, 32'h0000_3000, 1'b0, b_acc);
			issue_read(1'b1, 32'h0000_3400, 1'b0, b_other);
		join
		wait_reads_done();

		// line write and uncached write with read-back
		issue_write(32'h0000_4000, 1'b0, random_line());
		wait_writes_done();
		issue_read(1'b1, 32'h0000_4000, 1'b0, b_acc);
		issue_write(32'h0000_4100, 1'b1, random_line());
		wait_writes_done();
		issue_read(1'b1, 32'h0000_4100, 1'b1, b_acc);
		wait_reads_done();

		// reads to the line in flight wait for its response
		b_start = b_seen;
		issue_write(32'h0000_5000, 1'b0, random_line());
		issue_read(1'b0, 32'h0000_5000, 1'b0, b_acc);
		assert (b_acc > b_start)
			else abort_test("instruction read to the written address was accepted too early");
		wait_reads_done();
		b_start = b_seen;
		issue_write(32'h0000_5000, 1'b0, random_line());
		issue_read(1'b1, 32'h0000_5000, 1'b1, b_acc);
		assert (b_acc > b_start)
			else abort_test("data read to the written address was accepted too early");
		wait_reads_done();

		// a read to another line does not wait for the write
		b_start = b_seen;
		issue_write(32'h0000_5000, 1'b0, random_line());
		issue_read(1'b1, 32'h0000_6000, 1'b0, b_acc);
		assert (b_acc == b_start) else abort_test("read to another address waited for the write");
		wait_reads_done();
		wait_writes_done();

		// random mix over a few lines
		for (int i = 0; i < 40; i++) begin
			addr = 32'h0001_0000 + ($urandom % 8) * 32'h40;
			case ($urandom % 3)
				0: begin
					wait_reads_done(); // no write under a running burst
					issue_write(addr, ($urandom % 4) == 0, random_line());
				end
				1: issue_read(1'b0, addr, 1'b0, b_acc);
				default: issue_read(1'b1, addr, ($urandom % 3) == 0, b_acc);
			endcase
		end
		wait_reads_done();
		wait_writes_done();

		if (rd_q.size() == 0 && wr_q.size() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			abort_test("transactions still outstanding at the end of the run");
		end
	end

endmodule

// ==== sources.f ====
+incdir+logic
logic/axi_bridge_pkg.sv
logic/read_arbiter.sv
logic/read_channel.sv
logic/write_channel.sv
logic/axi_sram_bridge.sv
verification/tb_axi_mem.sv
verification/tb_axi_sram_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP := tb_axi_sram_bridge
FILELIST := sources.f
OBJ_DIR := obj_dir
LOG := sim.log
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
